/* rtl/correlator_settings.svh */
`ifndef CORRELATOR_SETTINGS_SVH
`define CORRELATOR_SETTINGS_SVH

// Detector channels and the pairs between them.
`define NUM_LINES 4
`define NUM_BASELINES 6

// Every counter wraps at this width.
`define COUNT_WIDTH 16

// UART bit period in intclk cycles.
`define CLKS_PER_BIT 16

// ********************
// Packet layout
// ********************
`define PACKET_HEADER 8'hA5
`define PACKET_BYTES 22

`endif

/* rtl/correlator_pkg.sv */
package correlator_pkg;

	`include "correlator_settings.svh"

	typedef logic [`COUNT_WIDTH-1:0] count_t;

	// Host command bytes.
	typedef enum logic [7:0] {
		CMD_START      = 8'h01,
		CMD_STOP       = 8'h02,
		CMD_CLEAR      = 8'h03,
		CMD_SET_INVERT = 8'h04
	} cmd_opcode_t;

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} uart_state_t;

	typedef enum logic {
		WAIT_CMD,
		WAIT_ARG
	} parse_state_t;

	// Framer sequencer states.
	typedef enum logic [1:0] {
		FRAME_IDLE,
		FRAME_SEND,
		FRAME_WAIT_DONE
	} frame_state_t;

endpackage

/* rtl/uart_rx.sv */
`timescale 1ns/1ns
`include "correlator_settings.svh"

module uart_rx (
	input  logic       intclk,
	input  logic       arst_n,
	input  logic       rx_line,
	output logic [7:0] rx_data,
	output logic       rx_valid
);
	import correlator_pkg::*;

	localparam int CNT_W = $clog2(`CLKS_PER_BIT);
	localparam int HALF_BIT = `CLKS_PER_BIT / 2;

	uart_state_t      state;
	logic             rx_meta;
	logic             rx_sync;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]       bit_idx;
	logic             bit_end;

	assign bit_end = (baud_cnt == CNT_W'(`CLKS_PER_BIT - 1));

	// Line idles high.
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx_line;
			rx_sync <= rx_meta;
		end
	end

	// ********************
	// Bit sampling FSM
	// ********************
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				IDLE: begin
					baud_cnt <= '0;
					if (!rx_sync) begin
						state <= START;
					end
				end
				START: begin
					if (baud_cnt == CNT_W'(HALF_BIT - 1)) begin
						// A high line at mid start bit is a glitch.
						baud_cnt <= '0;
						bit_idx  <= '0;
						state    <= rx_sync ? IDLE : DATA;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				DATA: begin
					baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= STOP;
						end
					end
				end
				STOP: begin
					baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
					if (bit_end) begin
						// Framing check on the stop bit.
						rx_valid <= rx_sync;
						state    <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// LSB first.
	always_ff @(posedge intclk) begin
		if (state == DATA && bit_end) begin
			rx_data <= {rx_sync, rx_data[7:1]};
		end
	end

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/1ns
`include "correlator_settings.svh"

module uart_tx (
	input  logic       intclk,
	input  logic       arst_n,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	output logic       tx_line,
	output logic       tx_busy
);
	import correlator_pkg::*;

	localparam int CNT_W = $clog2(`CLKS_PER_BIT);

	uart_state_t      state;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift_reg;
	logic             bit_end;

	assign bit_end = (baud_cnt == CNT_W'(`CLKS_PER_BIT - 1));
	assign tx_busy = (state != IDLE);

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			tx_line  <= 1'b1;
		end else begin
			case (state)
				IDLE: begin
					baud_cnt <= '0;
					if (tx_start) begin
						tx_line <= 1'b0;
						state   <= START;
					end
				end
				START: begin
					baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
					if (bit_end) begin
						bit_idx <= '0;
						tx_line <= shift_reg[0];
						state   <= DATA;
					end
				end
				DATA: begin
					baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							tx_line <= 1'b1;
							state   <= STOP;
						end else begin
							tx_line <= shift_reg[1];
						end
					end
				end
				STOP: begin
					baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
					if (bit_end) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Byte latch and shifter.
	always_ff @(posedge intclk) begin
		if (state == IDLE && tx_start) begin
			shift_reg <= tx_byte;
		end else if (state == DATA && bit_end) begin
			shift_reg <= {1'b0, shift_reg[7:1]};
		end
	end

endmodule

/* rtl/cmd_parser.sv */
`timescale 1ns/1ns
`include "correlator_settings.svh"

module cmd_parser (
	input  logic                  intclk,
	input  logic                  arst_n,
	input  logic [7:0]            rx_data,
	input  logic                  rx_valid,
	output logic                  integrating,
	output logic                  clear_counts,
	output logic                  send_request,
	output logic [`NUM_LINES-1:0] invert_mask
);
	import correlator_pkg::*;

	parse_state_t state;
	cmd_opcode_t  opcode;

	assign opcode = cmd_opcode_t'(rx_data);

	// ********************
	// Command decode
	// ********************
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			state        <= WAIT_CMD;
			integrating  <= 1'b0;
			clear_counts <= 1'b0;
			send_request <= 1'b0;
			invert_mask  <= '0;
		end else begin
			// Strobes last one cycle.
			clear_counts <= 1'b0;
			send_request <= 1'b0;
			if (rx_valid) begin
				case (state)
					WAIT_CMD: begin
						case (opcode)
							CMD_START: begin
								integrating <= 1'b1;
							end
							CMD_STOP: begin
								integrating  <= 1'b0;
								send_request <= 1'b1;
							end
							CMD_CLEAR: begin
								clear_counts <= 1'b1;
							end
							CMD_SET_INVERT: begin
								state <= WAIT_ARG;
							end
							default: begin
								// Unknown bytes are ignored.
								state <= WAIT_CMD;
							end
						endcase
					end
					WAIT_ARG: begin
						// Argument byte of the invert command.
						invert_mask <= rx_data[`NUM_LINES-1:0];
						state       <= WAIT_CMD;
					end
					default: state <= WAIT_CMD;
				endcase
			end
		end
	end

endmodule

/* rtl/pulse_correlator.sv */
`timescale 1ns/1ns
`include "correlator_settings.svh"

module pulse_correlator (
	input  logic                                        intclk,
	input  logic                                        arst_n,
	input  logic [`NUM_LINES-1:0]                       line_in,
	input  logic [`NUM_LINES-1:0]                       invert_mask,
	input  logic                                        integrating,
	input  logic                                        clear_counts,
	output correlator_pkg::count_t [`NUM_LINES-1:0]     channel_counts,
	output correlator_pkg::count_t [`NUM_BASELINES-1:0] baseline_counts
);
	import correlator_pkg::*;

	logic [`NUM_LINES-1:0]     line_meta;
	logic [`NUM_LINES-1:0]     line_sync;
	logic [`NUM_LINES-1:0]     line_level;
	logic [`NUM_LINES-1:0]     line_pulse;
	logic [`NUM_BASELINES-1:0] coincidence;

	// ********************
	// Line conditioning
	// ********************
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			line_meta <= '0;
			line_sync <= '0;
		end else begin
			line_meta <= line_in;
			line_sync <= line_meta;
		end
	end

	// Rising edge after the optional inversion.
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			line_level <= '0;
			line_pulse <= '0;
		end else begin
			line_level <= line_sync ^ invert_mask;
			line_pulse <= (line_sync ^ invert_mask) & ~line_level;
		end
	end

	// Pair (i,j) maps to baseline i*(2N-i-1)/2 + j-i-1.
	for (genvar i = 0; i < `NUM_LINES; i++) begin : g_row
		for (genvar j = i + 1; j < `NUM_LINES; j++) begin : g_col
			localparam int BASE = i * (2 * `NUM_LINES - i - 1) / 2 + j - i - 1;

			assign coincidence[BASE] = line_pulse[i] & line_pulse[j];
		end
	end

	// ********************
	// Counters
	// ********************
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			channel_counts  <= '0;
			baseline_counts <= '0;
		end else if (clear_counts) begin
			channel_counts  <= '0;
			baseline_counts <= '0;
		end else if (integrating) begin
			for (int c = 0; c < `NUM_LINES; c++) begin
				channel_counts[c] <= channel_counts[c] + count_t'(line_pulse[c]);
			end
			for (int b = 0; b < `NUM_BASELINES; b++) begin
				baseline_counts[b] <= baseline_counts[b] + count_t'(coincidence[b]);
			end
		end
	end

endmodule

/* rtl/packet_framer.sv */
`timescale 1ns/1ns
`include "correlator_settings.svh"

module packet_framer (
	input  logic                                        intclk,
	input  logic                                        arst_n,
	input  logic                                        send_request,
	input  correlator_pkg::count_t [`NUM_LINES-1:0]     channel_counts,
	input  correlator_pkg::count_t [`NUM_BASELINES-1:0] baseline_counts,
	input  logic                                        tx_busy,
	output logic                                        tx_start,
	output logic [7:0]                                  tx_byte
);
	import correlator_pkg::*;

	localparam int COUNT_BYTES = `COUNT_WIDTH / 8;
	localparam int PAYLOAD_BYTES = `PACKET_BYTES - 2;
	localparam int BASE_OFFSET = `NUM_LINES * COUNT_BYTES;
	localparam int IDX_W = $clog2(`PACKET_BYTES);

	frame_state_t     state;
	logic [IDX_W-1:0] byte_idx;
	logic [7:0]       checksum;
	logic [7:0]       cur_byte;
	logic             accept;
	logic [7:0]       snapshot [PAYLOAD_BYTES];

	assign accept = (state == FRAME_IDLE) && send_request;

	// Counts high byte first.
	always_ff @(posedge intclk) begin
		if (accept) begin
			for (int c = 0; c < `NUM_LINES; c++) begin
				for (int k = 0; k < COUNT_BYTES; k++) begin
					snapshot[c*COUNT_BYTES + k] <= channel_counts[c][(COUNT_BYTES-1-k)*8 +: 8];
				end
			end
			for (int b = 0; b < `NUM_BASELINES; b++) begin
				for (int k = 0; k < COUNT_BYTES; k++) begin
					snapshot[BASE_OFFSET + b*COUNT_BYTES + k] <=
						baseline_counts[b][(COUNT_BYTES-1-k)*8 +: 8];
				end
			end
		end
	end

	always_comb begin
		if (byte_idx == '0) begin
			cur_byte = `PACKET_HEADER;
		end else if (byte_idx == IDX_W'(`PACKET_BYTES - 1)) begin
			cur_byte = checksum;
		end else begin
			cur_byte = snapshot[byte_idx - 1'b1];
		end
	end

	// ********************
	// Byte sequencer
	// ********************
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= FRAME_IDLE;
			byte_idx <= '0;
			checksum <= '0;
			tx_start <= 1'b0;
			tx_byte  <= '0;
		end else begin
			tx_start <= 1'b0;
			case (state)
				FRAME_IDLE: begin
					if (send_request) begin
						byte_idx <= '0;
						checksum <= '0;
						state    <= FRAME_SEND;
					end
				end
				FRAME_SEND: begin
					if (!tx_busy) begin
						tx_start <= 1'b1;
						tx_byte  <= cur_byte;
						checksum <= checksum ^ cur_byte;
						state    <= FRAME_WAIT_DONE;
					end
				end
				FRAME_WAIT_DONE: begin
					// Busy rises a cycle after the start strobe.
					if (!tx_busy && !tx_start) begin
						if (byte_idx == IDX_W'(`PACKET_BYTES - 1)) begin
							state <= FRAME_IDLE;
						end else begin
							byte_idx <= byte_idx + 1'b1;
							state    <= FRAME_SEND;
						end
					end
				end
				default: state <= FRAME_IDLE;
			endcase
		end
	end

endmodule

/* rtl/photon_correlator.sv */
`timescale 1ns/1ns
`include "correlator_settings.svh"

module photon_correlator (
	input  logic                  intclk,
	input  logic                  arst_n,
	input  logic [`NUM_LINES-1:0] line_in,
	input  logic                  uart_rx_line,
	output logic                  uart_tx_line
);
	import correlator_pkg::*;

	logic [7:0]                      rx_data;
	logic                            rx_valid;
	logic                            integrating;
	logic                            clear_counts;
	logic                            send_request;
	logic [`NUM_LINES-1:0]           invert_mask;
	count_t [`NUM_LINES-1:0]         channel_counts;
	count_t [`NUM_BASELINES-1:0]     baseline_counts;
	logic                            tx_start;
	logic [7:0]                      tx_byte;
	logic                            tx_busy;

	// ********************
	// Host link
	// ********************
	uart_rx u_uart_rx (
		.intclk   (intclk),
		.arst_n   (arst_n),
		.rx_line  (uart_rx_line),
		.rx_data  (rx_data),
		.rx_valid (rx_valid)
	);

	cmd_parser u_cmd_parser (
		.intclk       (intclk),
		.arst_n       (arst_n),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid),
		.integrating  (integrating),
		.clear_counts (clear_counts),
		.send_request (send_request),
		.invert_mask  (invert_mask)
	);

	pulse_correlator u_pulse_correlator (
		.intclk          (intclk),
		.arst_n          (arst_n),
		.line_in         (line_in),
		.invert_mask     (invert_mask),
		.integrating     (integrating),
		.clear_counts    (clear_counts),
		.channel_counts  (channel_counts),
		.baseline_counts (baseline_counts)
	);

	// Result path back to the host.
	packet_framer u_packet_framer (
		.intclk          (intclk),
		.arst_n          (arst_n),
		.send_request    (send_request),
		.channel_counts  (channel_counts),
		.baseline_counts (baseline_counts),
		.tx_busy         (tx_busy),
		.tx_start        (tx_start),
		.tx_byte         (tx_byte)
	);

	uart_tx u_uart_tx (
		.intclk   (intclk),
		.arst_n   (arst_n),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.tx_line  (uart_tx_line),
		.tx_busy  (tx_busy)
	);

endmodule

/* verification/tb_photon_correlator.sv */
`timescale 1ns/1ns
`include "correlator_settings.svh"

module tb_photon_correlator;
	import correlator_pkg::*;

	localparam int RECV_TIMEOUT = 40 * `CLKS_PER_BIT;

	logic                  intclk;
	logic                  arst_n;
	logic [`NUM_LINES-1:0] line_in;
	logic                  uart_rx_line;
	logic                  uart_tx_line;

	integer                seed;
	logic [`NUM_LINES-1:0] inv_mask;
	logic                  model_on;
	count_t                exp_ch [`NUM_LINES];
	count_t                exp_bl [`NUM_BASELINES];
	count_t                got_ch [`NUM_LINES];
	count_t                got_bl [`NUM_BASELINES];

	photon_correlator i_dut (
		.intclk       (intclk),
		.arst_n       (arst_n),
		.line_in      (line_in),
		.uart_rx_line (uart_rx_line),
		.uart_tx_line (uart_tx_line)
	);

	always #5 intclk = ~intclk;

	// ********************
	// Checks
	// ********************
	task automatic abort_run(input string reason);
		$display("failure: %s", reason);
		$display("TEST FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("error %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "byte mismatch");
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		if (got !== exp) begin
			$display("error %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "count mismatch");
		end
	endtask

	task automatic compare_counts();
		for (int c = 0; c < `NUM_LINES; c++) begin
			check_count($sformatf("channel_counts[%0d]", c), got_ch[c], exp_ch[c]);
		end
		for (int b = 0; b < `NUM_BASELINES; b++) begin
			check_count($sformatf("baseline_counts[%0d]", b), got_bl[b], exp_bl[b]);
		end
	endtask

	// ********************
	// Reference model
	// ********************
	task automatic model_clear();
		for (int c = 0; c < `NUM_LINES; c++) begin
			exp_ch[c] = '0;
		end
		for (int b = 0; b < `NUM_BASELINES; b++) begin
			exp_bl[b] = '0;
		end
	endtask

	// Pairs in order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3).
	task automatic model_pulse(input logic [`NUM_LINES-1:0] mask);
		int b;
		b = 0;
		for (int c = 0; c < `NUM_LINES; c++) begin
			if (mask[c]) begin
				exp_ch[c] = exp_ch[c] + count_t'(1);
			end
		end
		for (int i = 0; i < `NUM_LINES; i++) begin
			for (int j = i + 1; j < `NUM_LINES; j++) begin
				if (mask[i] && mask[j]) begin
					exp_bl[b] = exp_bl[b] + count_t'(1);
				end
				b++;
			end
		end
	endtask

	// ********************
	// Host UART
	// ********************
	task automatic uart_send(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge intclk);
			uart_rx_line <= frame[i];
			repeat (`CLKS_PER_BIT - 1) @(posedge intclk);
		end
	endtask

	task automatic uart_recv(output logic [7:0] data);
		int waited;
		waited = 0;
		do begin
			@(negedge intclk);
			waited++;
			if (waited > RECV_TIMEOUT) begin
				abort_run("no start bit seen on uart_tx_line");
			end
		end while (uart_tx_line !== 1'b0);
		// Middle of the start bit.
		repeat (`CLKS_PER_BIT / 2) @(negedge intclk);
		if (uart_tx_line !== 1'b0) begin
			abort_run("start bit on uart_tx_line too short");
		end
		for (int i = 0; i < 8; i++) begin
			repeat (`CLKS_PER_BIT) @(negedge intclk);
			data[i] = uart_tx_line;
		end
		repeat (`CLKS_PER_BIT) @(negedge intclk);
		if (uart_tx_line !== 1'b1) begin
			abort_run("stop bit missing on uart_tx_line");
		end
	endtask

	task automatic read_packet();
		logic [7:0] pkt [`PACKET_BYTES];
		logic [7:0] rx_byte;
		logic [7:0] sum;
		sum = '0;
		for (int i = 0; i < `PACKET_BYTES; i++) begin
			uart_recv(rx_byte);
			pkt[i] = rx_byte;
		end
		check_byte("packet header", pkt[0], `PACKET_HEADER);
		for (int i = 0; i < `PACKET_BYTES - 1; i++) begin
			sum = sum ^ pkt[i];
		end
		check_byte("packet checksum", pkt[`PACKET_BYTES-1], sum);
		for (int c = 0; c < `NUM_LINES; c++) begin
			got_ch[c] = {pkt[1 + 2*c], pkt[2 + 2*c]};
		end
		for (int b = 0; b < `NUM_BASELINES; b++) begin
			got_bl[b] = {pkt[1 + 2*`NUM_LINES + 2*b], pkt[2 + 2*`NUM_LINES + 2*b]};
		end
	endtask

	// The packet starts before the stop bit of the command ends.
	task automatic stop_and_read();
		model_on = 1'b0;
		fork
			uart_send(CMD_STOP);
			read_packet();
		join
		compare_counts();
	endtask

	task automatic start_integration();
		uart_send(CMD_START);
		model_on = 1'b1;
	endtask

	task automatic clear_all();
		uart_send(CMD_CLEAR);
		model_clear();
	endtask

	task automatic set_invert(input logic [`NUM_LINES-1:0] mask);
		uart_send(CMD_SET_INVERT);
		uart_send({{(8-`NUM_LINES){1'b0}}, mask});
		inv_mask = mask;
		@(posedge intclk);
		line_in <= mask;
	endtask

	task automatic expect_line_idle(input int cycles);
		repeat (cycles) begin
			@(negedge intclk);
			if (uart_tx_line !== 1'b1) begin
				abort_run("uart_tx_line left idle without a request");
			end
		end
	endtask

	// ********************
	// Pulse drivers
	// ********************
	task automatic send_pulse(input logic [`NUM_LINES-1:0] mask);
		if (model_on) begin
			model_pulse(mask);
		end
		@(posedge intclk);
		line_in <= inv_mask ^ mask;
		repeat (2) @(posedge intclk);
		@(posedge intclk);
		line_in <= inv_mask;
		repeat (2) @(posedge intclk);
	endtask

	task automatic drive_pulses(input logic [`NUM_LINES-1:0] mask, input int n);
		repeat (n) send_pulse(mask);
	endtask

	// ********************
	// Directed tests
	// ********************
	task automatic reset_idle_packet();
		expect_line_idle(20 * `CLKS_PER_BIT);
		model_clear();
		stop_and_read();
	endtask

	task automatic separated_pulses();
		int                    n [`NUM_LINES];
		logic [`NUM_LINES-1:0] mask;
		clear_all();
		start_integration();
		for (int c = 0; c < `NUM_LINES; c++) begin
			n[c] = int'($unsigned($random(seed)) % 20) + 1;
			mask = '0;
			mask[c] = 1'b1;
			drive_pulses(mask, n[c]);
		end
		stop_and_read();
	endtask

	task automatic coincident_pairs();
		logic [`NUM_LINES-1:0] masks [9];
		masks = '{4'b0011, 4'b0101, 4'b1001, 4'b0110, 4'b1010,
			4'b1100, 4'b0111, 4'b1111, 4'b0010};
		clear_all();
		start_integration();
		for (int k = 0; k < 9; k++) begin
			drive_pulses(masks[k], k % 3 + 1);
		end
		stop_and_read();
	endtask

	task automatic inverted_and_gated();
		clear_all();
		set_invert(4'b0100);
		// Not integrating yet.
		drive_pulses(4'b1111, 3);
		start_integration();
		drive_pulses(4'b0100, 5);
		drive_pulses(4'b0110, 2);
		drive_pulses(4'b1101, 3);
		stop_and_read();
		drive_pulses(4'b0101, 4);
		stop_and_read();
		clear_all();
		stop_and_read();
		set_invert('0);
	endtask

	task automatic dropped_request();
		clear_all();
		start_integration();
		drive_pulses(4'b0001, 4);
		drive_pulses(4'b1010, 3);
		model_on = 1'b0;
		// A clear and then a second stop land while the first packet is on the line.
		fork
			begin
				uart_send(CMD_STOP);
				uart_send(CMD_CLEAR);
				uart_send(CMD_STOP);
			end
			read_packet();
		join
		compare_counts();
		model_clear();
		expect_line_idle(40 * `CLKS_PER_BIT);
		start_integration();
		drive_pulses(4'b0011, 2);
		uart_send(8'h5A);
		drive_pulses(4'b1100, 3);
		stop_and_read();
	endtask

	initial begin
		intclk       = 1'b0;
		arst_n       = 1'b0;
		line_in      = '0;
		uart_rx_line = 1'b1;
		seed         = 32'h9f17fb9c;
		inv_mask     = '0;
		model_on     = 1'b0;
		model_clear();
		repeat (8) @(posedge intclk);
		arst_n <= 1'b1;
		repeat (2) @(posedge intclk);

		reset_idle_packet();
		separated_pulses();
		coincident_pairs();
		inverted_and_gated();
		dropped_request();

		$display("TEST PASS");
		$finish;
	end

endmodule

/* photon_correlator.f */
+incdir+rtl
rtl/correlator_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/cmd_parser.sv
rtl/pulse_correlator.sv
rtl/packet_framer.sv
rtl/photon_correlator.sv
verification/tb_photon_correlator.sv

/* build.sh */
#!/bin/sh
# Compile the photon_correlator testbench with Verilator and run it.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
	-f photon_correlator.f \
	--top-module tb_photon_correlator \
	--Mdir obj_dir \
	-o tb_photon_correlator
status=$?
if [ $status -ne 0 ]; then
	echo "build.sh: verilator compile failed with status $status"
	exit $status
fi

./obj_dir/tb_photon_correlator
status=$?
if [ $status -ne 0 ]; then
	echo "build.sh: simulation failed with status $status"
	exit $status
fi

exit 0
